// File: bench/mon_lookup_tb.sv
// Traffic monitor testbench that checks random rules and tuples against a reference model
module mon_lookup_tb;
	import mon_pkg::*;

	localparam int rule_depth = 32;
	localparam int clk_period = 100;
	localparam int rw_count = 40;
	localparam int num_bursts = 6;
	localparam int burst_len = 24;
	// Bus accesses take under four cycles each and a burst two per tuple plus the drain
	localparam int num_accesses = num_regs + 2 * rule_depth * num_cols + 5 * rw_count
		+ 2 * num_regs + num_bursts * num_stats + 32;
	localparam int timeout_cycles = 4 * num_accesses + num_bursts * (2 * burst_len + 8) + 500;

	logic Bus2IP_Clk = 1'b0;
	logic rst_n = 1'b0;
	logic [addr_width-1:0] Bus2IP_Addr = '0;
	logic [1:0] Bus2IP_CS = '0;
	logic Bus2IP_RNW = 1'b1;
	logic [bus_width-1:0] Bus2IP_Data = '0;
	logic [bus_width-1:0] IP2Bus_Data;
	logic IP2Bus_RdAck;
	logic IP2Bus_WrAck;
	logic IP2Bus_Error;
	logic tuple_valid = 1'b0;
	logic [ip_width-1:0] tuple_sip = '0;
	logic [ip_width-1:0] tuple_dip = '0;
	logic [proto_width-1:0] tuple_proto = '0;
	logic [port_width-1:0] tuple_sport = '0;
	logic [port_width-1:0] tuple_dport = '0;
	logic [bytes_width-1:0] tuple_bytes = '0;
	logic [stamp_width-1:0] stamp_counter = '0;

	int seed = 94601;

	// Reference model state
	logic [31:0] mrules [rule_depth][num_cols];
	logic [31:0] m_pkt = '0;
	logic [31:0] m_bytes = '0;
	logic [31:0] m_tcp = '0;
	logic [31:0] m_udp = '0;
	logic [63:0] m_time = '0;
	logic m_freeze = 1'b0;
	logic m_clear = 1'b0;

	// Two-stage copy of the matcher and counter pipeline
	logic d1_hit = 1'b0;
	logic d2_hit = 1'b0;
	logic [15:0] d1_bytes = '0;
	logic [15:0] d2_bytes = '0;
	logic [7:0] d1_proto = '0;
	logic [7:0] d2_proto = '0;
	logic [63:0] d2_stamp = '0;

	mon_lookup_top #(.rule_depth (rule_depth)) UUT (.*);

	always #(clk_period / 2) Bus2IP_Clk = ~Bus2IP_Clk;

	always @(posedge Bus2IP_Clk) stamp_counter <= stamp_counter + 1'b1;

	task automatic stop_run(input string reason);
		$display("%s", reason);
		$display("Testbench failed");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else
			stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	// Bits under a set mask come from the rule and the rest from rnd
	function automatic logic [31:0] masked_pick(input logic [31:0] value, mask, rnd);
		return (value & mask) | (rnd & ~mask);
	endfunction

	function automatic logic model_match(input logic [31:0] sip, dip, ports, input logic [7:0] proto);
		for (int r = 0; r < rule_depth; r++) begin
			if ((((sip ^ mrules[r][col_sip]) & mrules[r][col_sip_mask]) == 0) &&
				(((dip ^ mrules[r][col_dip]) & mrules[r][col_dip_mask]) == 0) &&
				(((ports ^ mrules[r][col_ports]) & mrules[r][col_ports_mask]) == 0) &&
				(((proto ^ mrules[r][col_proto][7:0]) & mrules[r][col_proto_mask][7:0]) == 0))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// Effect lands two cycles after the strobe
	always @(negedge Bus2IP_Clk) begin
		if (d2_hit && !m_clear && !m_freeze) begin
			m_pkt = m_pkt + 1;
			m_bytes = m_bytes + d2_bytes;
			m_tcp = m_tcp + (d2_proto == 8'd6);
			m_udp = m_udp + (d2_proto == 8'd17);
			m_time = d2_stamp;
		end
		d2_hit = d1_hit;
		d2_bytes = d1_bytes;
		d2_proto = d1_proto;
		d2_stamp = stamp_counter;
		d1_hit = rst_n && tuple_valid &&
			model_match(tuple_sip, tuple_dip, {tuple_sport, tuple_dport}, tuple_proto);
		d1_bytes = tuple_bytes;
		d1_proto = tuple_proto;
	end

	task automatic bus_access(input logic bar1_sel, rd, input int word, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge Bus2IP_Clk);
		Bus2IP_CS <= bar1_sel ? 2'b01 : 2'b10;
		Bus2IP_RNW <= rd;
		Bus2IP_Addr <= word << 2;
		Bus2IP_Data <= wdata;
		@(posedge Bus2IP_Clk);
		Bus2IP_CS <= 2'b00;
		@(negedge Bus2IP_Clk);
		assert (!IP2Bus_RdAck && !IP2Bus_WrAck) else
			stop_run("Bus ack arrived one cycle after the strobe instead of two");
		@(negedge Bus2IP_Clk);
		assert (rd ? (IP2Bus_RdAck && !IP2Bus_WrAck) : (IP2Bus_WrAck && !IP2Bus_RdAck)) else
			stop_run("Bus ack missing two cycles after the strobe");
		rdata = IP2Bus_Data;
		err = IP2Bus_Error;
	endtask

	task automatic expect_access(input string name, input logic bar1_sel, rd, input int word,
		input logic [31:0] wdata, exp_data, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		bus_access(bar1_sel, rd, word, wdata, rdata, err);
		check_value({name, " error flag"}, exp_err, err);
		if (rd)
			check_value(name, exp_data, rdata);
	endtask

	task automatic rule_write(input int row, col, input logic [31:0] data);
		expect_access("rule write", 1'b1, 1'b0, row * num_cols + col, data, 0, 1'b0);
		mrules[row][col] = data;
	endtask

	task automatic set_ctrl(input int idx, input logic val);
		expect_access("control write", 1'b0, 1'b0, idx, {31'd0, val}, 0, 1'b0);
		if (idx == reg_freeze) begin
			m_freeze = val;
		end else begin
			m_clear = val;
			if (val) begin
				m_pkt = '0;
				m_bytes = '0;
				m_tcp = '0;
				m_udp = '0;
				m_time = '0;
			end
		end
	endtask

	task automatic check_stats(input string name);
		logic [31:0] exp_words [num_stats];
		exp_words = '{m_pkt, m_bytes, m_tcp, m_udp, m_time[31:0], m_time[63:32]};
		for (int i = 0; i < num_stats; i++)
			expect_access($sformatf("%s reg %0d", name, reg_pkt_cnt + i), 1'b0, 1'b1,
				reg_pkt_cnt + i, 0, exp_words[i], 1'b0);
	endtask

	task automatic random_rw();
		logic [31:0] rnd;
		logic [31:0] data;
		int row;
		int col;
		int bad_row;
		for (int i = 0; i < rw_count; i++) begin
			rnd = $random(seed);
			data = $random(seed);
			row = rnd[4:0];
			col = rnd[7:5];
			bad_row = rule_depth + rnd[15:8];
			rule_write(row, col, data);
			expect_access("rule readback", 1'b1, 1'b1, row * num_cols + col, 0, data, 1'b0);
			expect_access("rule bad row write", 1'b1, 1'b0, bad_row * num_cols + col, ~data, 0, 1'b1);
			expect_access("rule bad row read", 1'b1, 1'b1, bad_row * num_cols + col, 0, 0, 1'b1);
			// Aliased row must not see the bad write
			expect_access("rule alias row", 1'b1, 1'b1, (bad_row % rule_depth) * num_cols + col,
				0, mrules[bad_row % rule_depth][col], 1'b0);
		end
	endtask

	task automatic program_rules();
		logic [31:0] rnd;
		for (int r = 0; r < rule_depth; r++) begin
			rnd = $random(seed);
			rule_write(r, col_sip, $random(seed) | 32'h8000_0000);
			rule_write(r, col_sip_mask, 32'hffff_ffff << rnd[3:0]);
			rule_write(r, col_dip, $random(seed));
			rule_write(r, col_dip_mask, 32'hffff_ffff << rnd[7:4]);
			rule_write(r, col_ports, $random(seed));
			rule_write(r, col_ports_mask,
				rnd[8] ? 32'hffff_0000 : (rnd[9] ? 32'h0000_ffff : 32'hffff_ffff));
			rule_write(r, col_proto, 32'(rnd[10] ? 8'd6 : (rnd[11] ? 8'd17 : rnd[23:16])));
			rule_write(r, col_proto_mask, rnd[12] ? 32'h0 : 32'hff);
		end
	endtask

	// About half the tuples are built to hit a chosen rule
	task automatic send_burst();
		logic [31:0] rnd;
		logic [31:0] sip;
		logic [31:0] dip;
		logic [31:0] pw;
		logic [31:0] pp;
		int row;
		for (int i = 0; i < burst_len; i++) begin
			rnd = $random(seed);
			row = rnd[4:0];
			pp = rnd[6] ? 32'd6 : (rnd[7] ? 32'd17 : 32'(rnd[31:24]));
			if (rnd[5]) begin
				sip = masked_pick(mrules[row][col_sip], mrules[row][col_sip_mask], $random(seed));
				dip = masked_pick(mrules[row][col_dip], mrules[row][col_dip_mask], $random(seed));
				pw = masked_pick(mrules[row][col_ports], mrules[row][col_ports_mask], $random(seed));
				pp = masked_pick(mrules[row][col_proto], mrules[row][col_proto_mask], pp);
			end else begin
				sip = $random(seed) | 32'h1;
				dip = $random(seed);
				pw = $random(seed);
			end
			@(posedge Bus2IP_Clk);
			tuple_valid <= 1'b1;
			tuple_sip <= sip;
			tuple_dip <= dip;
			tuple_sport <= pw[31:16];
			tuple_dport <= pw[15:0];
			tuple_proto <= pp[7:0];
			tuple_bytes <= 16'($random(seed));
			if (rnd[9]) begin
				@(posedge Bus2IP_Clk);
				tuple_valid <= 1'b0;
			end
		end
		@(posedge Bus2IP_Clk);
		tuple_valid <= 1'b0;
		repeat (3) @(negedge Bus2IP_Clk);
	endtask

	initial begin
		#(clk_period * timeout_cycles);
		stop_run("Watchdog timeout, the tests did not finish in time");
	end

	initial begin
		// Value columns start at zero and mask columns at all ones
		for (int r = 0; r < rule_depth; r++)
			for (int c = 0; c < num_cols; c++)
				mrules[r][c] = (c == col_sip_mask || c == col_dip_mask ||
					c == col_ports_mask || c == col_proto_mask) ? 32'hffff_ffff : 32'h0;
		repeat (3) @(posedge Bus2IP_Clk);
		rst_n <= 1'b1;

		// Reset values
		for (int i = 0; i < num_regs; i++)
			expect_access("reset register", 1'b0, 1'b1, i, 0, 0, 1'b0);
		for (int r = 0; r < rule_depth; r++)
			for (int c = 0; c < num_cols; c++)
				expect_access("reset rule word", 1'b1, 1'b1, r * num_cols + c, 0, mrules[r][c], 1'b0);

		// Readback and illegal accesses
		random_rw();
		for (int i = reg_pkt_cnt; i < num_regs; i++) begin
			expect_access("stats write", 1'b0, 1'b0, i, $random(seed), 0, 1'b1);
			expect_access("stats after write", 1'b0, 1'b1, i, 0, 0, 1'b0);
		end
		expect_access("bar0 past map write", 1'b0, 1'b0, num_regs + reg_rst_stats, 1, 0, 1'b1);
		expect_access("bar0 past map write", 1'b0, 1'b0, num_regs + reg_freeze, 1, 0, 1'b1);
		expect_access("bar0 past map read", 1'b0, 1'b1, 2 * num_regs + 3, 0, 0, 1'b1);
		expect_access("rst_stats after bad write", 1'b0, 1'b1, reg_rst_stats, 0, 0, 1'b0);
		expect_access("freeze after bad write", 1'b0, 1'b1, reg_freeze, 0, 0, 1'b0);

		// Matching traffic
		program_rules();
		for (int b = 0; b < num_bursts - 2; b++) begin
			send_burst();
			check_stats("traffic");
		end

		// Freeze and then clear
		set_ctrl(reg_freeze, 1'b1);
		expect_access("freeze readback", 1'b0, 1'b1, reg_freeze, 0, 1, 1'b0);
		send_burst();
		check_stats("frozen");
		set_ctrl(reg_freeze, 1'b0);
		set_ctrl(reg_rst_stats, 1'b1);
		expect_access("rst_stats readback", 1'b0, 1'b1, reg_rst_stats, 0, 1, 1'b0);
		set_ctrl(reg_rst_stats, 1'b0);
		check_stats("cleared");
		send_burst();
		check_stats("after clear");

		$display("Testbench passed");
		$finish;
	end

endmodule

// File: compile.f
logic/mon_pkg.sv
logic/ipif_bus_if.sv
logic/bus_decoder.sv
logic/stats_regs.sv
logic/rule_table.sv
logic/tuple_matcher.sv
logic/stats_counters.sv
logic/mon_lookup_top.sv
bench/mon_lookup_tb.sv

// File: logic/bus_decoder.sv
// Bus decoder, routes each chip select to its slave and registers the merged response
module bus_decoder (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	input  logic [mon_pkg::addr_width-1:0] addr,
	input  logic [1:0] cs,
	input  logic rnw,
	input  logic [mon_pkg::bus_width-1:0] wdata,
	output logic [mon_pkg::bus_width-1:0] rdata,
	output logic rdack,
	output logic wrack,
	output logic error,
	ipif_bus_if.decoder bar0,
	ipif_bus_if.decoder bar1
);
	import mon_pkg::*;

	// CS bit 1 is BAR0, bit 0 is BAR1
	assign bar0.cs = cs[1];
	assign bar1.cs = cs[0];

	// Request fields go to both slaves
	assign bar0.rnw = rnw;
	assign bar1.rnw = rnw;
	assign bar0.word_addr = addr[addr_width-1:2];
	assign bar1.word_addr = addr[addr_width-1:2];
	assign bar0.wdata = wdata;
	assign bar1.wdata = wdata;

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n) begin
			rdack <= 1'b0;
			wrack <= 1'b0;
			error <= 1'b0;
		end else begin
			rdack <= bar0.rdack | bar1.rdack;
			wrack <= bar0.wrack | bar1.wrack;
			error <= bar0.error | bar1.error;
		end
	end

	// Data of the acking slave, zero when nobody reads
	always_ff @(posedge Bus2IP_Clk) begin
		case ({bar0.rdack, bar1.rdack})
			2'b10: rdata <= bar0.rdata;
			2'b01: rdata <= bar1.rdata;
			default: rdata <= '0;
		endcase
	end

endmodule

// File: logic/ipif_bus_if.sv
// Internal register bus to one slave, and the matcher to counters hit path
interface ipif_bus_if;
	import mon_pkg::*;

	// Request from the decoder
	logic cs;
	logic rnw;
	logic [addr_width-3:0] word_addr;
	logic [bus_width-1:0] wdata;

	// Response, one cycle after cs
	logic [bus_width-1:0] rdata;
	logic rdack;
	logic wrack;
	logic error;

	modport decoder (output cs, rnw, word_addr, wdata, input rdata, rdack, wrack, error);
	modport slave (input cs, rnw, word_addr, wdata, output rdata, rdack, wrack, error);
endinterface

interface match_if;
	import mon_pkg::*;

	logic hit;
	logic [bytes_width-1:0] hit_bytes;
	logic hit_tcp;
	logic hit_udp;

	modport source (output hit, hit_bytes, hit_tcp, hit_udp);
	modport sink (input hit, hit_bytes, hit_tcp, hit_udp);
endinterface

// File: logic/mon_lookup_top.sv
// Traffic monitor top level with the register bus, rule table, matcher and counters
module mon_lookup_top #(
	parameter int rule_depth = 32
) (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	input  logic [mon_pkg::addr_width-1:0] Bus2IP_Addr,
	input  logic [1:0] Bus2IP_CS,
	input  logic Bus2IP_RNW,
	input  logic [mon_pkg::bus_width-1:0] Bus2IP_Data,
	output logic [mon_pkg::bus_width-1:0] IP2Bus_Data,
	output logic IP2Bus_RdAck,
	output logic IP2Bus_WrAck,
	output logic IP2Bus_Error,
	input  logic tuple_valid,
	input  logic [mon_pkg::ip_width-1:0] tuple_sip,
	input  logic [mon_pkg::ip_width-1:0] tuple_dip,
	input  logic [mon_pkg::proto_width-1:0] tuple_proto,
	input  logic [mon_pkg::port_width-1:0] tuple_sport,
	input  logic [mon_pkg::port_width-1:0] tuple_dport,
	input  logic [mon_pkg::bytes_width-1:0] tuple_bytes,
	input  logic [mon_pkg::stamp_width-1:0] stamp_counter
);
	import mon_pkg::*;

	logic rst_stats;
	logic stats_freeze;
	logic [num_stats-1:0][bus_width-1:0] stats;
	logic [rule_depth-1:0][num_cols-1:0][bus_width-1:0] rules;

	ipif_bus_if bar0_bus ();
	ipif_bus_if bar1_bus ();
	match_if match_bus ();

	bus_decoder u_bus_decoder (
		.Bus2IP_Clk (Bus2IP_Clk),
		.rst_n (rst_n),
		.addr (Bus2IP_Addr),
		.cs (Bus2IP_CS),
		.rnw (Bus2IP_RNW),
		.wdata (Bus2IP_Data),
		.rdata (IP2Bus_Data),
		.rdack (IP2Bus_RdAck),
		.wrack (IP2Bus_WrAck),
		.error (IP2Bus_Error),
		.bar0 (bar0_bus.decoder),
		.bar1 (bar1_bus.decoder)
	);

	stats_regs u_stats_regs (
		.Bus2IP_Clk (Bus2IP_Clk),
		.rst_n (rst_n),
		.bus (bar0_bus.slave),
		.stats (stats),
		.rst_stats (rst_stats),
		.stats_freeze (stats_freeze)
	);

	rule_table #(.rule_depth (rule_depth)) u_rule_table (
		.Bus2IP_Clk (Bus2IP_Clk),
		.rst_n (rst_n),
		.bus (bar1_bus.slave),
		.rules (rules)
	);

	tuple_matcher #(.rule_depth (rule_depth)) u_tuple_matcher (
		.Bus2IP_Clk (Bus2IP_Clk),
		.rst_n (rst_n),
		.rules (rules),
		.tuple_valid (tuple_valid),
		.tuple_sip (tuple_sip),
		.tuple_dip (tuple_dip),
		.tuple_proto (tuple_proto),
		.tuple_sport (tuple_sport),
		.tuple_dport (tuple_dport),
		.tuple_bytes (tuple_bytes),
		.hit_out (match_bus.source)
	);

	stats_counters u_stats_counters (
		.Bus2IP_Clk (Bus2IP_Clk),
		.rst_n (rst_n),
		.rst_stats (rst_stats),
		.stats_freeze (stats_freeze),
		.stamp_counter (stamp_counter),
		.hit_in (match_bus.sink),
		.stats (stats)
	);

endmodule

// File: logic/mon_pkg.sv
// Traffic monitor package with widths, register map, rule columns and protocol numbers
package mon_pkg;

	// Bus words
	localparam int bus_width = 32;
	localparam int addr_width = 32;

	// Header tuple fields
	localparam int ip_width = 32;
	localparam int proto_width = 8;
	localparam int port_width = 16;
	localparam int bytes_width = 16;
	localparam int stamp_width = 64;

	// Rule table columns, value and mask in pairs
	localparam int num_cols = 8;
	localparam int col_sip = 0;
	localparam int col_sip_mask = 1;
	localparam int col_dip = 2;
	localparam int col_dip_mask = 3;
	localparam int col_ports = 4;
	localparam int col_ports_mask = 5;
	localparam int col_proto = 6;
	localparam int col_proto_mask = 7;

	// BAR0 register map
	localparam int reg_rst_stats = 0;
	localparam int reg_freeze = 1;
	localparam int reg_pkt_cnt = 2;
	localparam int reg_bytes_cnt = 3;
	localparam int reg_tcp_cnt = 4;
	localparam int reg_udp_cnt = 5;
	localparam int reg_time_low = 6;
	localparam int reg_time_high = 7;
	localparam int num_regs = 8;
	localparam int num_stats = 6;

	localparam logic [proto_width-1:0] proto_tcp = 8'd6;
	localparam logic [proto_width-1:0] proto_udp = 8'd17;

	// L4 ports word, source port in the upper half
	typedef union packed {
		logic [bus_width-1:0] raw;
		struct packed {
			logic [port_width-1:0] sport;
			logic [port_width-1:0] dport;
		} ports;
	} l4_ports_t;

endpackage

// File: logic/rule_table.sv
// BAR1 slave holding the monitoring rules, one bus word per rule column
module rule_table #(
	parameter int rule_depth = 32
) (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	ipif_bus_if.slave bus,
	output logic [rule_depth-1:0][mon_pkg::num_cols-1:0][mon_pkg::bus_width-1:0] rules
);
	import mon_pkg::*;

	localparam int row_bits = $clog2(rule_depth);
	localparam int col_bits = $clog2(num_cols);

	logic [row_bits-1:0] row;
	logic [col_bits-1:0] col;
	logic row_err;

	// Word address is row * 8 + column
	assign col = bus.word_addr[col_bits-1:0];
	assign row = bus.word_addr[col_bits +: row_bits];
	assign row_err = (bus.word_addr >> col_bits) >= rule_depth;

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n) begin
			// Masks sit at odd columns and start fully set,
			// so an unwritten rule only hits the all-zero tuple
			for (int r = 0; r < rule_depth; r++) begin
				for (int c = 0; c < num_cols; c++) begin
					rules[r][c] <= (c % 2 == 1) ? '1 : '0;
				end
			end
		end else if (bus.cs && !bus.rnw && !row_err) begin
			rules[row][col] <= bus.wdata;
		end
	end

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n) begin
			bus.rdack <= 1'b0;
			bus.wrack <= 1'b0;
			bus.error <= 1'b0;
		end else begin
			bus.rdack <= bus.cs && bus.rnw;
			bus.wrack <= bus.cs && !bus.rnw;
			bus.error <= bus.cs && row_err;
		end
	end

	// Rows past the table read as zero
	always_ff @(posedge Bus2IP_Clk) begin
		if (row_err)
			bus.rdata <= '0;
		else
			bus.rdata <= rules[row][col];
	end

endmodule

// File: logic/stats_counters.sv
// Matched traffic counters and stats time, with clear and freeze control
module stats_counters (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	input  logic rst_stats,
	input  logic stats_freeze,
	input  logic [mon_pkg::stamp_width-1:0] stamp_counter,
	match_if.sink hit_in,
	output logic [mon_pkg::num_stats-1:0][mon_pkg::bus_width-1:0] stats
);
	import mon_pkg::*;

	// Statistics words follow the BAR0 order
	localparam int stat_base = reg_pkt_cnt;

	logic [bus_width-1:0] pkt_cnt;
	logic [bus_width-1:0] bytes_cnt;
	logic [bus_width-1:0] tcp_cnt;
	logic [bus_width-1:0] udp_cnt;
	logic [stamp_width-1:0] stats_time;

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n) begin
			pkt_cnt <= '0;
			bytes_cnt <= '0;
			tcp_cnt <= '0;
			udp_cnt <= '0;
			stats_time <= '0;
		end else if (rst_stats) begin
			pkt_cnt <= '0;
			bytes_cnt <= '0;
			tcp_cnt <= '0;
			udp_cnt <= '0;
			stats_time <= '0;
		end else if (!stats_freeze && hit_in.hit) begin
			// All counters wrap
			pkt_cnt <= pkt_cnt + 1'b1;
			bytes_cnt <= bytes_cnt + bus_width'(hit_in.hit_bytes);
			tcp_cnt <= tcp_cnt + bus_width'(hit_in.hit_tcp);
			udp_cnt <= udp_cnt + bus_width'(hit_in.hit_udp);
			stats_time <= stamp_counter;
		end
	end

	assign stats[reg_pkt_cnt - stat_base] = pkt_cnt;
	assign stats[reg_bytes_cnt - stat_base] = bytes_cnt;
	assign stats[reg_tcp_cnt - stat_base] = tcp_cnt;
	assign stats[reg_udp_cnt - stat_base] = udp_cnt;
	assign stats[reg_time_low - stat_base] = stats_time[bus_width-1:0];
	assign stats[reg_time_high - stat_base] = stats_time[stamp_width-1:bus_width];

endmodule

// File: logic/stats_regs.sv
// BAR0 slave with the clear and freeze controls and the read-only statistics words
module stats_regs (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	ipif_bus_if.slave bus,
	input  logic [mon_pkg::num_stats-1:0][mon_pkg::bus_width-1:0] stats,
	output logic rst_stats,
	output logic stats_freeze
);
	import mon_pkg::*;

	localparam int idx_bits = $clog2(num_regs);

	logic [idx_bits-1:0] reg_idx;
	logic in_range;
	logic ro_write;
	logic access_err;
	logic [bus_width-1:0] read_word;

	assign reg_idx = bus.word_addr[idx_bits-1:0];
	assign in_range = bus.word_addr < num_regs;

	// Statistics words cannot be written
	assign ro_write = !bus.rnw && (reg_idx >= reg_pkt_cnt);
	assign access_err = !in_range || ro_write;

	always_comb begin
		read_word = '0;
		if (in_range) begin
			case (reg_idx)
				reg_rst_stats: read_word = {{(bus_width-1){1'b0}}, rst_stats};
				reg_freeze: read_word = {{(bus_width-1){1'b0}}, stats_freeze};
				default: read_word = stats[reg_idx - reg_pkt_cnt];
			endcase
		end
	end

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_stats <= 1'b0;
			stats_freeze <= 1'b0;
			bus.rdack <= 1'b0;
			bus.wrack <= 1'b0;
			bus.error <= 1'b0;
		end else begin
			bus.rdack <= bus.cs && bus.rnw;
			bus.wrack <= bus.cs && !bus.rnw;
			bus.error <= bus.cs && access_err;

			// Only bit 0 of the two control words is kept
			if (bus.cs && !bus.rnw && !access_err) begin
				if (reg_idx == reg_rst_stats)
					rst_stats <= bus.wdata[0];
				if (reg_idx == reg_freeze)
					stats_freeze <= bus.wdata[0];
			end
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		bus.rdata <= read_word;
	end

endmodule

// File: logic/tuple_matcher.sv
// Masked match of each header tuple against every rule, result registered for the counters
module tuple_matcher #(
	parameter int rule_depth = 32
) (
	input  logic Bus2IP_Clk,
	input  logic rst_n,
	input  logic [rule_depth-1:0][mon_pkg::num_cols-1:0][mon_pkg::bus_width-1:0] rules,
	input  logic tuple_valid,
	input  logic [mon_pkg::ip_width-1:0] tuple_sip,
	input  logic [mon_pkg::ip_width-1:0] tuple_dip,
	input  logic [mon_pkg::proto_width-1:0] tuple_proto,
	input  logic [mon_pkg::port_width-1:0] tuple_sport,
	input  logic [mon_pkg::port_width-1:0] tuple_dport,
	input  logic [mon_pkg::bytes_width-1:0] tuple_bytes,
	match_if.source hit_out
);
	import mon_pkg::*;

	l4_ports_t tuple_ports;
	logic [rule_depth-1:0] rule_match;

	always_comb begin
		tuple_ports.ports.sport = tuple_sport;
		tuple_ports.ports.dport = tuple_dport;
	end

	for (genvar r = 0; r < rule_depth; r++) begin : g_rule
		l4_ports_t rule_ports;
		l4_ports_t ports_mask;

		assign rule_ports.raw = rules[r][col_ports];
		assign ports_mask.raw = rules[r][col_ports_mask];

		// A set mask bit means the bit is compared
		assign rule_match[r] =
			(((tuple_sip ^ rules[r][col_sip]) & rules[r][col_sip_mask]) == '0) &&
			(((tuple_dip ^ rules[r][col_dip]) & rules[r][col_dip_mask]) == '0) &&
			(((tuple_ports.raw ^ rule_ports.raw) & ports_mask.raw) == '0) &&
			(((tuple_proto ^ rules[r][col_proto][proto_width-1:0]) &
				rules[r][col_proto_mask][proto_width-1:0]) == '0);
	end

	always_ff @(posedge Bus2IP_Clk or negedge rst_n) begin
		if (!rst_n)
			hit_out.hit <= 1'b0;
		else
			hit_out.hit <= tuple_valid && (|rule_match);
	end

	// Qualified by hit downstream
	always_ff @(posedge Bus2IP_Clk) begin
		hit_out.hit_bytes <= tuple_bytes;
		hit_out.hit_tcp <= tuple_proto == proto_tcp;
		hit_out.hit_udp <= tuple_proto == proto_udp;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds and runs the traffic monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module mon_lookup_tb \
	-f compile.f \
	-Mdir obj_dir -o mon_lookup_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/mon_lookup_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit 1
fi

echo "Simulation completed"
exit 0
